// File: vlog.f
+incdir+include
hw/mips_isa_pkg.sv
hw/id_ctrl_pkg.sv
hw/id_if.sv
hw/inst_decoder.sv
hw/operand_forward.sv
hw/id_ex_stage.sv
hw/id_top.sv
tb/id_properties.sv
tb/id_tb.sv

// File: tb/id_tb.sv
`timescale 1ns/100ps
`include "id_consts.svh"

module id_tb;
    import id_ctrl_pkg::*;

    localparam int NUM_INST        = 2000;
    localparam int EDGE_POLL_LIMIT = 100;

    // three-register SPECIAL function codes
    localparam logic [12:0][5:0] RRR_FN = {6'h04, 6'h06, 6'h07, 6'h20, 6'h21, 6'h22,
                                           6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [`WORD_W-1:0]      inst;
    logic [`WORD_W-1:0]      reg_data1;
    logic [`WORD_W-1:0]      reg_data2;
    logic                    ex_wreg;
    logic [`REG_ADDR_W-1:0]  ex_wd;
    logic [`WORD_W-1:0]      ex_wdata;
    logic                    mem_wreg;
    logic [`REG_ADDR_W-1:0]  mem_wd;
    logic [`WORD_W-1:0]      mem_wdata;
    logic                    en_read1;
    logic                    en_read2;
    logic [`REG_ADDR_W-1:0]  reg_addr1;
    logic [`REG_ADDR_W-1:0]  reg_addr2;
    aluop_e                  aluop;
    alusel_e                 alusel;
    logic [`WORD_W-1:0]      reg1;
    logic [`WORD_W-1:0]      reg2;
    logic [`REG_ADDR_W-1:0]  wd;
    logic                    wreg;
    logic                    invalid_inst;

    logic [`WORD_W-1:0]      rf [32];
    logic [31:0]             rng_state = 32'h1e15_6fd0;
    int                      fall_count = 0;

    // reference decode of the word in decode
    logic                    m_valid;
    aluop_e                  m_aluop;
    alusel_e                 m_alusel;
    logic [`REG_ADDR_W-1:0]  m_wd;
    logic                    m_en1;
    logic                    m_en2;
    logic [`WORD_W-1:0]      m_imm;

    always #2 clk = ~clk;

    always @(negedge clk) begin
        fall_count <= fall_count + 1;
    end

    // register file answers in the same cycle
    assign reg_data1 = rf[reg_addr1];
    assign reg_data2 = rf[reg_addr2];

    id_top u_dut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .inst_i         (inst),
        .reg_data1_i    (reg_data1),
        .reg_data2_i    (reg_data2),
        .ex_wreg_i      (ex_wreg),
        .ex_wd_i        (ex_wd),
        .ex_wdata_i     (ex_wdata),
        .mem_wreg_i     (mem_wreg),
        .mem_wd_i       (mem_wd),
        .mem_wdata_i    (mem_wdata),
        .en_reg_read1_o (en_read1),
        .en_reg_read2_o (en_read2),
        .reg_addr1_o    (reg_addr1),
        .reg_addr2_o    (reg_addr2),
        .aluop_o        (aluop),
        .alusel_o       (alusel),
        .reg1_o         (reg1),
        .reg2_o         (reg2),
        .wd_o           (wd),
        .wreg_o         (wreg),
        .invalid_inst_o (invalid_inst)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;

        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // mostly kept encodings, one in eight a raw word
    function automatic logic [31:0] make_inst();
        logic [31:0] a;
        logic [31:0] b;
        logic [5:0]  op;
        logic [5:0]  fn;

        a = next_rand();
        b = next_rand();
        op = 6'h08 + 6'(a[7:5]);
        fn = (a[6:5] == 2'd0) ? 6'h00 : ((a[6:5] == 2'd1) ? 6'h02 : 6'h03);
        if (a[2:0] == 3'd0)
            return b;
        case (a[4:3])
            2'd2:    return {6'd0, 5'd0, b[20:6], fn};
            2'd3:    return {op, b[25:0]};
            default: return {6'd0, b[25:11], 5'd0, RRR_FN[a[8:5] % 13]};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model

    task automatic decode_model(input logic [31:0] w);
        logic [5:0] op;
        logic [5:0] fn;

        op = w[31:26];
        fn = w[5:0];
        m_valid = 1'b1;
        m_aluop = ALU_NOP;
        m_wd    = w[20:16];
        m_en1   = 1'b1;
        m_en2   = 1'b0;
        m_imm   = {{16{w[15]}}, w[15:0]};
        if (op == 6'h00) begin
            m_wd  = w[15:11];
            m_en2 = 1'b1;
            m_imm = '0;
            case (fn)
                6'h00, 6'h04: m_aluop = ALU_SLL;
                6'h02, 6'h06: m_aluop = ALU_SRL;
                6'h03, 6'h07: m_aluop = ALU_SRA;
                6'h20:        m_aluop = ALU_ADD;
                6'h21:        m_aluop = ALU_ADDU;
                6'h22:        m_aluop = ALU_SUB;
                6'h23:        m_aluop = ALU_SUBU;
                6'h24:        m_aluop = ALU_AND;
                6'h25:        m_aluop = ALU_OR;
                6'h26:        m_aluop = ALU_XOR;
                6'h27:        m_aluop = ALU_NOR;
                6'h2a:        m_aluop = ALU_SLT;
                6'h2b:        m_aluop = ALU_SLTU;
                default:      m_valid = 1'b0;
            endcase
            if (fn inside {6'h00, 6'h02, 6'h03}) begin
                // shamt goes in as operand 1
                m_en1 = 1'b0;
                m_imm = {27'd0, w[10:6]};
                if (w[25:21] != 5'd0)
                    m_valid = 1'b0;
            end else if (w[10:6] != 5'd0) begin
                m_valid = 1'b0;
            end
        end else begin
            case (op)
                6'h08:        m_aluop = ALU_ADDI;
                6'h09:        m_aluop = ALU_ADDIU;
                6'h0a:        m_aluop = ALU_SLT;
                6'h0b:        m_aluop = ALU_SLTU;
                6'h0c:        m_aluop = ALU_AND;
                6'h0d, 6'h0f: m_aluop = ALU_OR;
                6'h0e:        m_aluop = ALU_XOR;
                default:      m_valid = 1'b0;
            endcase
            if (op inside {6'h0c, 6'h0d, 6'h0e})
                m_imm = {16'd0, w[15:0]};
            if (op == 6'h0f)
                m_imm = {w[15:0], 16'd0};
        end
        case (m_aluop)
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: m_alusel = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         m_alusel = SEL_SHIFT;
            default:                           m_alusel = SEL_ARITH;
        endcase
        if (!m_valid) begin
            m_aluop  = ALU_NOP;
            m_alusel = SEL_NOP;
            m_wd     = '0;
            m_en1    = 1'b0;
            m_en2    = 1'b0;
            m_imm    = '0;
        end
    endtask

    // execute first, then memory, then the register file
    function automatic logic [31:0] forward_operand(input logic en, input logic [4:0] addr);
        if (!en)
            return m_imm;
        if (ex_wreg && ex_wd == addr)
            return ex_wdata;
        if (mem_wreg && mem_wd == addr)
            return mem_wdata;
        return rf[addr];
    endfunction

    function automatic logic [4:0] pick_dest(input logic [2:0] sel, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] other);
        if (sel < 3'd3)
            return rs;
        return (sel < 3'd6) ? rt : other;
    endfunction

    task automatic drive_forwarding(input logic [4:0] rs, input logic [4:0] rt);
        logic [31:0] r;

        r = next_rand();
        ex_wreg   = r[0];
        ex_wd     = pick_dest(r[3:1], rs, rt, r[8:4]);
        mem_wreg  = r[9];
        mem_wd    = pick_dest(r[12:10], rs, rt, r[17:13]);
        ex_wdata  = next_rand();
        mem_wdata = next_rand();
    endtask

    ////////////////////////////////////////////////////////////
    // checking and timing helpers

    task automatic check_value(input string test, input int idx,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s inst %0d expected %h actual %h", test, idx, expected, actual);
            $display("Test FAILED");
            $fatal(1, "%s mismatch", test);
        end
    endtask

    task automatic wait_falling_edge();
        int target;
        int polls;

        target = fall_count + 1;
        polls = 0;
        while (fall_count < target) begin
            #0.1;
            polls++;
            assert (polls < EDGE_POLL_LIMIT) else begin
                $display("timed out waiting for a falling clock edge");
                $display("Test FAILED");
                $fatal(1, "clock stalled");
            end
        end
        assert (u_dut.u_props.fail_count == 0) else begin
            $display("a bound assertion on the DUT ports failed");
            $display("Test FAILED");
            $fatal(1, "bound assertion failure");
        end
    endtask

    initial begin
        int          idx;
        logic [31:0] cur;
        logic        have_pend;
        logic        p_valid;
        aluop_e      p_aluop;
        alusel_e     p_alusel;
        logic [4:0]  p_wd;
        logic [31:0] p_reg1;
        logic [31:0] p_reg2;

        rst_n     = 1'b0;
        inst      = '0;
        ex_wreg   = 1'b0;
        ex_wd     = '0;
        ex_wdata  = '0;
        mem_wreg  = 1'b0;
        mem_wd    = '0;
        mem_wdata = '0;
        have_pend = 1'b0;
        for (idx = 0; idx < 32; idx++)
            rf[idx] = next_rand();
        repeat (8) wait_falling_edge();

        check_value("reset aluop", 0, ALU_NOP, aluop);
        check_value("reset alusel", 0, SEL_NOP, alusel);
        check_value("reset wd", 0, 0, wd);
        check_value("reset wreg", 0, 0, wreg);
        check_value("reset invalid", 0, 0, invalid_inst);
        check_value("reset reg1", 0, 0, reg1);
        check_value("reset reg2", 0, 0, reg2);
        check_value("reset en_read1", 0, 0, en_read1);
        check_value("reset en_read2", 0, 0, en_read2);

        cur   = make_inst();
        rst_n = 1'b1;
        inst  = cur;
        for (idx = 0; idx <= NUM_INST; idx++) begin
            wait_falling_edge();
            if (have_pend) begin
                check_value("decode aluop", idx - 1, p_aluop, aluop);
                check_value("decode alusel", idx - 1, p_alusel, alusel);
                check_value("decode wd", idx - 1, p_wd, wd);
                check_value("decode wreg", idx - 1, p_valid, wreg);
                check_value("bubble invalid", idx - 1, !p_valid, invalid_inst);
                check_value("operand reg1", idx - 1, p_reg1, reg1);
                check_value("operand reg2", idx - 1, p_reg2, reg2);
            end
            // last pass only drains the final instruction
            if (idx == NUM_INST)
                break;
            decode_model(cur);
            check_value("read_port addr1", idx, cur[25:21], reg_addr1);
            check_value("read_port addr2", idx, cur[20:16], reg_addr2);
            check_value("read_port en1", idx, m_en1, en_read1);
            check_value("read_port en2", idx, m_en2, en_read2);

            drive_forwarding(cur[25:21], cur[20:16]);
            p_valid   = m_valid;
            p_aluop   = m_aluop;
            p_alusel  = m_alusel;
            p_wd      = m_wd;
            p_reg1    = m_valid ? forward_operand(m_en1, cur[25:21]) : '0;
            p_reg2    = m_valid ? forward_operand(m_en2, cur[20:16]) : '0;
            have_pend = 1'b1;
            cur       = make_inst();
            inst      = cur;
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: tb/id_properties.sv
`timescale 1ns/100ps

module id_properties (
    input logic  clk,
    input logic  rst_n_i,
    input logic  en_reg_read1_o,
    input logic  en_reg_read2_o,
    input logic  wreg_o,
    input logic  invalid_inst_o
);

    // failed assertions so far
    int fail_count = 0;

    // a bubble never writes back
    bubble_no_write: assert property (@(posedge clk) invalid_inst_o |-> !wreg_o)
        else begin
            fail_count++;
            $error("wreg_o high while invalid_inst_o is high");
        end

    // nothing captured yet in the first cycle out of reset
    no_read_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (!en_reg_read1_o && !en_reg_read2_o))
        else begin
            fail_count++;
            $error("register read enabled in the first cycle after reset");
        end

endmodule

bind id_top id_properties u_props (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .en_reg_read1_o (en_reg_read1_o),
    .en_reg_read2_o (en_reg_read2_o),
    .wreg_o         (wreg_o),
    .invalid_inst_o (invalid_inst_o)
);

// File: hw/id_top.sv
`timescale 1ns/100ps
`include "id_consts.svh"

module id_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [`WORD_W-1:0]      inst_i,
    input  logic [`WORD_W-1:0]      reg_data1_i,
    input  logic [`WORD_W-1:0]      reg_data2_i,
    input  logic                    ex_wreg_i,
    input  logic [`REG_ADDR_W-1:0]  ex_wd_i,
    input  logic [`WORD_W-1:0]      ex_wdata_i,
    input  logic                    mem_wreg_i,
    input  logic [`REG_ADDR_W-1:0]  mem_wd_i,
    input  logic [`WORD_W-1:0]      mem_wdata_i,
    output logic                    en_reg_read1_o,
    output logic                    en_reg_read2_o,
    output logic [`REG_ADDR_W-1:0]  reg_addr1_o,
    output logic [`REG_ADDR_W-1:0]  reg_addr2_o,
    output id_ctrl_pkg::aluop_e     aluop_o,
    output id_ctrl_pkg::alusel_e    alusel_o,
    output logic [`WORD_W-1:0]      reg1_o,
    output logic [`WORD_W-1:0]      reg2_o,
    output logic [`REG_ADDR_W-1:0]  wd_o,
    output logic                    wreg_o,
    output logic                    invalid_inst_o
);

    dec_if dec_bus ();
    fwd_if fwd_bus ();

    logic [`WORD_W-1:0] op1;
    logic [`WORD_W-1:0] op2;

    ////////////////////////////////////////////////////////////
    // port mapping

    assign fwd_bus.ex_wreg   = ex_wreg_i;
    assign fwd_bus.ex_wd     = ex_wd_i;
    assign fwd_bus.ex_wdata  = ex_wdata_i;
    assign fwd_bus.mem_wreg  = mem_wreg_i;
    assign fwd_bus.mem_wd    = mem_wd_i;
    assign fwd_bus.mem_wdata = mem_wdata_i;

    // register file request, same cycle as decode
    assign en_reg_read1_o = dec_bus.en_read1;
    assign en_reg_read2_o = dec_bus.en_read2;
    assign reg_addr1_o    = dec_bus.read_addr1;
    assign reg_addr2_o    = dec_bus.read_addr2;

    ////////////////////////////////////////////////////////////
    // stage blocks

    inst_decoder u_inst_decoder (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .inst_i  (inst_i),
        .dec     (dec_bus.drv)
    );

    operand_forward u_operand_forward (
        .dec         (dec_bus.rd),
        .fwd         (fwd_bus.rd),
        .reg_data1_i (reg_data1_i),
        .reg_data2_i (reg_data2_i),
        .op1_o       (op1),
        .op2_o       (op2)
    );

    id_ex_stage u_id_ex_stage (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .dec            (dec_bus.rd),
        .op1_i          (op1),
        .op2_i          (op2),
        .aluop_o        (aluop_o),
        .alusel_o       (alusel_o),
        .reg1_o         (reg1_o),
        .reg2_o         (reg2_o),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .invalid_inst_o (invalid_inst_o)
    );

endmodule

// File: hw/id_ex_stage.sv
`timescale 1ns/100ps
`include "id_consts.svh"

module id_ex_stage (
    input  logic                    clk,
    input  logic                    rst_n_i,
    dec_if.rd                       dec,
    input  logic [`WORD_W-1:0]      op1_i,
    input  logic [`WORD_W-1:0]      op2_i,
    output id_ctrl_pkg::aluop_e     aluop_o,
    output id_ctrl_pkg::alusel_e    alusel_o,
    output logic [`WORD_W-1:0]      reg1_o,
    output logic [`WORD_W-1:0]      reg2_o,
    output logic [`REG_ADDR_W-1:0]  wd_o,
    output logic                    wreg_o,
    output logic                    invalid_inst_o
);
    import id_ctrl_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            aluop_o        <= ALU_NOP;
            alusel_o       <= SEL_NOP;
            reg1_o         <= '0;
            reg2_o         <= '0;
            wd_o           <= `NOP_REG_ADDR;
            wreg_o         <= 1'b0;
            invalid_inst_o <= 1'b0;
        end else if (dec.invalid) begin
            // bubble, nothing reaches execute
            aluop_o        <= ALU_NOP;
            alusel_o       <= SEL_NOP;
            reg1_o         <= '0;
            reg2_o         <= '0;
            wd_o           <= `NOP_REG_ADDR;
            wreg_o         <= 1'b0;
            invalid_inst_o <= 1'b1;
        end else begin
            aluop_o        <= dec.aluop;
            alusel_o       <= dec.alusel;
            reg1_o         <= op1_i;
            reg2_o         <= op2_i;
            wd_o           <= dec.wd;
            wreg_o         <= dec.wreg;
            invalid_inst_o <= 1'b0;
        end
    end

endmodule

// File: hw/operand_forward.sv
`timescale 1ns/100ps
`include "id_consts.svh"

module operand_forward (
    dec_if.rd                   dec,
    fwd_if.rd                   fwd,
    input  logic [`WORD_W-1:0]  reg_data1_i,
    input  logic [`WORD_W-1:0]  reg_data2_i,
    output logic [`WORD_W-1:0]  op1_o,
    output logic [`WORD_W-1:0]  op2_o
);

    // execute beats memory beats the register file
    function automatic logic [`WORD_W-1:0] pick_operand(
        input logic                    en_read,
        input logic [`REG_ADDR_W-1:0]  addr,
        input logic [`WORD_W-1:0]      rf_data
    );
        logic [`WORD_W-1:0] result;

        if (!en_read) begin
            result = dec.imm;
        end else if (fwd.ex_wreg && fwd.ex_wd == addr) begin
            result = fwd.ex_wdata;
        end else if (fwd.mem_wreg && fwd.mem_wd == addr) begin
            result = fwd.mem_wdata;
        end else begin
            result = rf_data;
        end
        return result;
    endfunction

    always_comb begin
        op1_o = pick_operand(dec.en_read1, dec.read_addr1, reg_data1_i);
    end

    // second operand from port 2
    always_comb begin
        op2_o = pick_operand(dec.en_read2, dec.read_addr2, reg_data2_i);
    end

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/100ps
`include "id_consts.svh"

module inst_decoder (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  mips_isa_pkg::inst_u  inst_i,
    dec_if.drv                   dec
);
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;

    inst_u               inst_q;
    logic                loaded_q;
    aluop_e              r_op;
    aluop_e              i_op;
    logic                r_shamt_form;
    logic [`WORD_W-1:0]  i_imm;

    function automatic alusel_e sel_of(input aluop_e op);
        case (op)
            ALU_OR, ALU_AND, ALU_XOR, ALU_NOR: sel_of = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA:         sel_of = SEL_SHIFT;
            ALU_NOP:                           sel_of = SEL_NOP;
            default:                           sel_of = SEL_ARITH;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_q   <= '0;
            loaded_q <= 1'b0;
        end else begin
            inst_q   <= inst_i;
            loaded_q <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // field decode

    always_comb begin
        case (inst_q.r.funct)
            FN_OR:           r_op = ALU_OR;
            FN_AND:          r_op = ALU_AND;
            FN_XOR:          r_op = ALU_XOR;
            FN_NOR:          r_op = ALU_NOR;
            FN_SLL, FN_SLLV: r_op = ALU_SLL;
            FN_SRL, FN_SRLV: r_op = ALU_SRL;
            FN_SRA, FN_SRAV: r_op = ALU_SRA;
            FN_ADD:          r_op = ALU_ADD;
            FN_ADDU:         r_op = ALU_ADDU;
            FN_SUB:          r_op = ALU_SUB;
            FN_SUBU:         r_op = ALU_SUBU;
            FN_SLT:          r_op = ALU_SLT;
            FN_SLTU:         r_op = ALU_SLTU;
            default:         r_op = ALU_NOP;
        endcase
    end

    // shamt forms need rs 0, the others need shamt 0
    assign r_shamt_form = inst_q.r.funct inside {FN_SLL, FN_SRL, FN_SRA};

    always_comb begin
        case (inst_q.i.op)
            OP_ORI, OP_LUI: i_op = ALU_OR;
            OP_ANDI:        i_op = ALU_AND;
            OP_XORI:        i_op = ALU_XOR;
            OP_ADDI:        i_op = ALU_ADDI;
            OP_ADDIU:       i_op = ALU_ADDIU;
            OP_SLTI:        i_op = ALU_SLT;
            OP_SLTIU:       i_op = ALU_SLTU;
            default:        i_op = ALU_NOP;
        endcase
    end

    always_comb begin
        case (inst_q.i.op)
            OP_ORI, OP_ANDI, OP_XORI:
                i_imm = {{(`WORD_W-`IMM_W){1'b0}}, inst_q.i.imm};
            OP_LUI:
                i_imm = {inst_q.i.imm, {(`WORD_W-`IMM_W){1'b0}}};
            default:
                i_imm = {{(`WORD_W-`IMM_W){inst_q.i.imm[`IMM_W-1]}}, inst_q.i.imm};
        endcase
    end

    ////////////////////////////////////////////////////////////
    // control toward forwarding and ID/EX

    assign dec.read_addr1 = inst_q.r.rs;
    assign dec.read_addr2 = inst_q.r.rt;

    always_comb begin
        dec.aluop    = ALU_NOP;
        dec.alusel   = SEL_NOP;
        dec.wd       = `NOP_REG_ADDR;
        dec.wreg     = 1'b0;
        dec.en_read1 = 1'b0;
        dec.en_read2 = 1'b0;
        dec.imm      = '0;
        // no flag until a word has been captured
        dec.invalid  = loaded_q;

        if (loaded_q && inst_q.r.op == OP_SPECIAL && r_op != ALU_NOP) begin
            if (r_shamt_form && inst_q.r.rs == '0) begin
                dec.aluop    = r_op;
                dec.alusel   = sel_of(r_op);
                dec.wd       = inst_q.r.rd;
                dec.wreg     = 1'b1;
                dec.en_read2 = 1'b1;
                dec.imm      = {{(`WORD_W-`SHAMT_W){1'b0}}, inst_q.r.shamt};
                dec.invalid  = 1'b0;
            end else if (!r_shamt_form && inst_q.r.shamt == '0) begin
                dec.aluop    = r_op;
                dec.alusel   = sel_of(r_op);
                dec.wd       = inst_q.r.rd;
                dec.wreg     = 1'b1;
                dec.en_read1 = 1'b1;
                dec.en_read2 = 1'b1;
                dec.invalid  = 1'b0;
            end
        end else if (loaded_q && i_op != ALU_NOP) begin
            dec.aluop    = i_op;
            dec.alusel   = sel_of(i_op);
            dec.wd       = inst_q.i.rt;
            dec.wreg     = 1'b1;
            dec.en_read1 = 1'b1;
            dec.imm      = i_imm;
            dec.invalid  = 1'b0;
        end
    end

endmodule

// File: hw/id_if.sv
`timescale 1ns/100ps
`include "id_consts.svh"

// decoded control of the instruction held in decode
interface dec_if;
    import id_ctrl_pkg::*;

    aluop_e                  aluop;
    alusel_e                 alusel;
    logic [`REG_ADDR_W-1:0]  wd;
    logic                    wreg;
    logic                    en_read1;
    logic                    en_read2;
    logic [`REG_ADDR_W-1:0]  read_addr1;
    logic [`REG_ADDR_W-1:0]  read_addr2;
    logic [`WORD_W-1:0]      imm;
    logic                    invalid;

    modport drv (output aluop, alusel, wd, wreg, en_read1, en_read2,
                 output read_addr1, read_addr2, imm, invalid);
    modport rd  (input  aluop, alusel, wd, wreg, en_read1, en_read2,
                 input  read_addr1, read_addr2, imm, invalid);
endinterface

// write-back results of execute and memory
interface fwd_if;
    logic                    ex_wreg;
    logic [`REG_ADDR_W-1:0]  ex_wd;
    logic [`WORD_W-1:0]      ex_wdata;
    logic                    mem_wreg;
    logic [`REG_ADDR_W-1:0]  mem_wd;
    logic [`WORD_W-1:0]      mem_wdata;

    modport rd (input ex_wreg, ex_wd, ex_wdata, mem_wreg, mem_wd, mem_wdata);
endinterface

// File: hw/id_ctrl_pkg.sv
package id_ctrl_pkg;

    // operation code toward execute
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_AND   = 8'b0010_0100,
        ALU_OR    = 8'b0010_0101,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_ADDI  = 8'b0101_0101,
        ALU_ADDIU = 8'b0101_0110,
        ALU_SLL   = 8'b0111_1100
    } aluop_e;

    // result class, picks the execute result mux
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alusel_e;

endpackage

// File: hw/mips_isa_pkg.sv
`include "id_consts.svh"

package mips_isa_pkg;

    // primary opcodes of the kept subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // SPECIAL function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef struct packed {
        opcode_e                 op;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`REG_ADDR_W-1:0]  rt;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`SHAMT_W-1:0]     shamt;
        funct_e                  funct;
    } r_fields_t;

    typedef struct packed {
        opcode_e                 op;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`REG_ADDR_W-1:0]  rt;
        logic [`IMM_W-1:0]       imm;
    } i_fields_t;

    // one word, R or I view picked by the opcode
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

endpackage

// File: include/id_consts.svh
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// data path and instruction word
`define WORD_W        32

// register file addressing
`define REG_ADDR_W    5
`define NOP_REG_ADDR  5'd0

// instruction fields
`define IMM_W         16
`define SHAMT_W       5

`endif
